// File: all.f
+incdir+tb
design/cpu_pkg.sv
design/inst_fetch.sv
design/reg_file.sv
design/inst_decode.sv
design/execute.sv
design/mem_writeback.sv
design/pipe_control.sv
design/cpu_top.sv
tb/tb_cpu_top.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - files:
      - design/cpu_pkg.sv
      - design/inst_fetch.sv
      - design/reg_file.sv
      - design/inst_decode.sv
      - design/execute.sv
      - design/mem_writeback.sv
      - design/pipe_control.sv
      - design/cpu_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_cpu_top.sv

// File: tb/tb_programs.svh
////////////////////////////////////////
// instruction encoders and test programs
// included inside the testbench module,
// each program refills the prog queue
////////////////////////////////////////
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

function automatic word_t rtype(logic [5:0] fn, int rd, int rs, int rt);
    return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

function automatic word_t itype(logic [5:0] op, int rt, int rs, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

task automatic alu_mix();
    prog.delete();
    for (int r = 1; r <= 4; r++)
        prog.push_back(itype(OP_LUI, r, 0, $urandom));
    for (int r = 1; r <= 4; r++)
        prog.push_back(itype(OP_ADDIU, r, r, $urandom));  // low half, may borrow
    prog.push_back(rtype(FN_ADDU, 5, 1, 2));
    prog.push_back(rtype(FN_SUBU, 6, 3, 4));
    prog.push_back(rtype(FN_AND, 7, 1, 3));
    prog.push_back(rtype(FN_OR, 8, 2, 4));
    prog.push_back(rtype(FN_XOR, 9, 1, 4));
    prog.push_back(rtype(FN_SLT, 10, 2, 3));
    prog.push_back(rtype(FN_SLT, 11, 3, 2));
    prog.push_back(itype(OP_ADDIU, 12, 4, $urandom));
    prog.push_back(itype(OP_LUI, 13, 0, $urandom));
endtask

task automatic forward_chain();
    prog.delete();
    prog.push_back(itype(OP_ADDIU, 1, 0, $urandom));
    prog.push_back(rtype(FN_ADDU, 2, 1, 1));  // distance 1
    prog.push_back(rtype(FN_SUBU, 3, 2, 1));  // distances 1 and 2
    prog.push_back(rtype(FN_XOR, 4, 3, 1));   // distances 1 and 3
    prog.push_back(rtype(FN_OR, 5, 2, 4));
    prog.push_back(rtype(FN_SLT, 6, 5, 3));
    prog.push_back(rtype(FN_AND, 7, 4, 6));
    prog.push_back(itype(OP_ADDIU, 1, 1, $urandom));
    prog.push_back(itype(OP_ADDIU, 1, 1, $urandom));
    prog.push_back(rtype(FN_ADDU, 8, 1, 7));  // newest r1 must win
endtask

task automatic store_load();
    int base;
    base = $urandom_range(0, 56) * 4;
    prog.delete();
    prog.push_back(itype(OP_ADDIU, 1, 0, $urandom));
    prog.push_back(itype(OP_LUI, 2, 0, $urandom));
    prog.push_back(itype(OP_ADDIU, 3, 0, base));
    prog.push_back(itype(OP_SW, 1, 3, 0));
    prog.push_back(itype(OP_SW, 2, 3, 4));
    prog.push_back(itype(OP_SW, 3, 0, 252));  // top word of the RAM
    prog.push_back(itype(OP_LW, 4, 3, 0));
    prog.push_back(rtype(FN_ADDU, 5, 4, 4));  // load-use on rs
    prog.push_back(itype(OP_LW, 6, 3, 4));
    prog.push_back(rtype(FN_SUBU, 7, 1, 6));  // load-use on rt
    prog.push_back(itype(OP_LW, 8, 0, 252));
    prog.push_back(itype(OP_SW, 8, 3, 8));    // store data straight from a load
    prog.push_back(itype(OP_LW, 9, 3, 8));
    prog.push_back(itype(OP_LW, 10, 9, 0));   // address from a load
endtask

task automatic branch_loop();
    int count;
    count = $urandom_range(2, 6);
    prog.delete();
    prog.push_back(itype(OP_ADDIU, 1, 0, count));
    prog.push_back(itype(OP_ADDIU, 2, 0, 0));
    prog.push_back(itype(OP_ADDIU, 2, 2, 3));  // loop body
    prog.push_back(itype(OP_ADDIU, 1, 1, -1));
    prog.push_back(itype(OP_BNE, 0, 1, -3));   // back to the body
    prog.push_back(itype(OP_BEQ, 0, 1, 2));    // taken, skips the next two
    prog.push_back(itype(OP_ADDIU, 3, 0, 'h111));
    prog.push_back(itype(OP_ADDIU, 4, 0, 'h222));
    prog.push_back(itype(OP_BEQ, 0, 2, 1));    // not taken
    prog.push_back(itype(OP_ADDIU, 5, 0, 'h333));
    prog.push_back(itype(OP_BNE, 5, 5, 1));    // not taken
    prog.push_back(itype(OP_ADDIU, 6, 2, 1));
endtask

task automatic zero_and_unknown();
    prog.delete();
    prog.push_back(itype(OP_ADDIU, 1, 0, $urandom));
    prog.push_back(itype(OP_ADDIU, 0, 1, $urandom));  // r0 target
    prog.push_back(rtype(FN_ADDU, 0, 1, 1));
    prog.push_back(itype(6'h3F, 1, 1, $urandom));      // unknown opcode aimed at r1
    prog.push_back(rtype(6'h3F, 2, 1, 1));             // unknown funct aimed at r2
    prog.push_back(rtype(FN_ADDU, 3, 1, 0));
    prog.push_back(rtype(FN_OR, 4, 2, 0));
    prog.push_back(rtype(FN_ADDU, 5, 0, 1));           // r0 still reads zero
endtask

`endif

// File: tb/tb_cpu_top.sv
////////////////////////////////////////
// directed tests checked against a
// reference interpreter of the subset
// DUT data RAM is not reset, so every
// program stores a word before it loads it
// ROM holds 64 words, the rest reads as nop
////////////////////////////////////////
`timescale 1ns/1ps

module tb_cpu_top;
    import cpu_pkg::*;

    localparam int ROM_WORDS = 64;
    localparam int DRAIN     = 8;  // quiet cycles after the last retirement

    logic       aclk;
    logic       arst_n;
    word_t      imem_addr;
    word_t      imem_data;
    word_t      debug_wb_pc;
    word_t      debug_wb_rf_wdata;
    logic [3:0] debug_wb_rf_wen;
    reg_idx_t   debug_wb_rf_wnum;

    word_t      rom [ROM_WORDS];
    word_t      prog [$];
    word_t      exp_pc [$];
    word_t      exp_data [$];
    reg_idx_t   exp_wnum [$];
    int         errors;
    int         budget;  // watchdog limit, grows with each test
    int         cycles;

    `include "tb_programs.svh"

    cpu_top dut0 (.*);

    always #4 aclk = ~aclk;

    assign imem_data = (imem_addr[31:2] < ROM_WORDS) ? rom[imem_addr[7:2]] : '0;

    always @(posedge aclk) begin
        cycles++;
        if (cycles > budget) begin
            $display("Timeout: the core stopped retiring after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_val(string sig, word_t got, word_t exp);
        assert (got === exp) else begin
            errors++;
            $display("Error %s: got %h, expected %h", sig, got, exp);
        end
    endtask

    task automatic check_wen();
        assert (debug_wb_rf_wen == 4'h0 || debug_wb_rf_wen == 4'hf) else begin
            errors++;
            $display("write enable %h is neither zero nor all ones", debug_wb_rf_wen);
        end
    endtask

    // golden model, no delay slot, fills the expected trace
    task automatic interpret();
        word_t    gpr [32];
        word_t    ram [64];
        word_t    pc;
        word_t    npc;
        word_t    ins;
        word_t    a;
        word_t    b;
        word_t    simm;
        word_t    addr;
        word_t    res;
        reg_idx_t dst;
        logic     wr;
        int       steps;
        gpr   = '{default: '0};
        ram   = '{default: '0};
        pc    = '0;
        steps = 0;
        exp_pc.delete();
        exp_data.delete();
        exp_wnum.delete();
        while (pc[31:2] < prog.size() && steps < 2000) begin
            ins  = prog[pc[31:2]];
            a    = gpr[ins[25:21]];
            b    = gpr[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            addr = a + simm;
            npc  = pc + 4;
            dst  = ins[20:16];
            res  = '0;
            wr   = 1'b1;
            case (ins[31:26])
                OP_SPECIAL: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: res = addr;
                OP_LUI:   res = {ins[15:0], 16'h0000};
                OP_LW:    res = ram[addr[7:2]];
                OP_SW: begin
                    wr = 1'b0;
                    ram[addr[7:2]] = b;
                end
                OP_BEQ, OP_BNE: begin
                    wr = 1'b0;
                    if ((a == b) == (ins[31:26] == OP_BEQ))
                        npc = pc + 4 + (simm << 2);
                end
                default: wr = 1'b0;  // unknown, nop
            endcase
            if (wr && dst != '0) begin
                gpr[dst] = res;
                exp_pc.push_back(pc);
                exp_data.push_back(res);
                exp_wnum.push_back(dst);
            end
            pc = npc;
            steps++;
        end
    endtask

    task automatic run_test(string name);
        int got;
        interpret();
        budget += 40 * exp_pc.size() + DRAIN + 4;
        $display("%s: %0d retirements expected", name, exp_pc.size());
        @(negedge aclk);
        arst_n = 1'b0;
        foreach (rom[i])
            rom[i] = (i < prog.size()) ? prog[i] : '0;
        repeat (2) @(negedge aclk);
        arst_n = 1'b1;
        got = 0;
        while (got < exp_pc.size()) begin
            @(posedge aclk);
            check_wen();
            if (debug_wb_rf_wen == 4'hf) begin
                check_val("debug_wb_pc", debug_wb_pc, exp_pc[got]);
                check_val("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data[got]);
                check_val("debug_wb_rf_wnum", word_t'(debug_wb_rf_wnum), word_t'(exp_wnum[got]));
                got++;
            end
        end
        repeat (DRAIN) begin
            @(posedge aclk);
            check_wen();
            assert (debug_wb_rf_wen == 4'h0) else begin
                errors++;
                $display("%s: retirement at pc %h beyond the expected trace", name, debug_wb_pc);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h73f3_0781));
        aclk   = 1'b0;
        arst_n = 1'b0;
        errors = 0;
        cycles = 0;
        budget = 0;
        foreach (rom[i])
            rom[i] = '0;
        alu_mix();
        run_test("alu");
        forward_chain();
        run_test("forwarding");
        store_load();
        run_test("load and store");
        branch_loop();
        run_test("branches");
        zero_and_unknown();
        run_test("r0 and unknown encodings");
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: design/cpu_top.sv
////////////////////////////////////////
// five-stage core, no external stalls
// imem port is a combinational ROM
// trace shows one retirement per wen
////////////////////////////////////////
`timescale 1ns/1ps

module cpu_top (
    input  logic              aclk,
    input  logic              arst_n,
    output cpu_pkg::word_t    imem_addr,
    input  cpu_pkg::word_t    imem_data,
    output cpu_pkg::word_t    debug_wb_pc,
    output cpu_pkg::word_t    debug_wb_rf_wdata,
    output logic [3:0]        debug_wb_rf_wen,
    output cpu_pkg::reg_idx_t debug_wb_rf_wnum
);
    import cpu_pkg::*;

    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    fwd_t     mem_fwd;
    fwd_t     wb_fwd;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    rs_val;
    word_t    rt_val;
    word_t    redirect_pc;
    logic     redirect;
    logic     load_use;
    logic     pc_wr;
    logic     if_wr;
    logic     if_flush;
    logic     id_flush;

    pipe_control u_control (.*);

    inst_fetch u_fetch (.*);

    reg_file u_regs (
        .wb (wb_fwd),
        .*
    );

    inst_decode u_decode (.*);

    execute u_execute (.*);

    mem_writeback u_mem_wb (.*);

endmodule

// File: design/pipe_control.sv
////////////////////////////////////////
// stall and flush causes to stage enables
// redirect wins over load-use
////////////////////////////////////////
`timescale 1ns/1ps

module pipe_control (
    input  logic load_use,
    input  logic redirect,
    output logic pc_wr,
    output logic if_wr,
    output logic if_flush,
    output logic id_flush
);

    logic hold;

    // a stall is dropped when the branch throws away the stalled instruction
    assign hold = load_use && !redirect;

    assign pc_wr    = !hold;
    assign if_wr    = !hold;
    assign if_flush = redirect;              // squash the wrong-path fetch
    assign id_flush = load_use || redirect;  // bubble into execute

endmodule

// File: design/mem_writeback.sv
////////////////////////////////////////
// internal word RAM, upper address bits
// and byte offset are ignored
// trace wen is all ones or all zeros
////////////////////////////////////////
`timescale 1ns/1ps

module mem_writeback (
    input  logic              aclk,
    input  logic              arst_n,
    input  cpu_pkg::ex_mem_t  ex_mem,
    output cpu_pkg::fwd_t     mem_fwd,
    output cpu_pkg::fwd_t     wb_fwd,
    output cpu_pkg::word_t    debug_wb_pc,
    output cpu_pkg::word_t    debug_wb_rf_wdata,
    output logic [3:0]        debug_wb_rf_wen,
    output cpu_pkg::reg_idx_t debug_wb_rf_wnum
);
    import cpu_pkg::*;

    word_t                dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0]   widx;
    mem_wb_t              mem_wb;

    assign widx = ex_mem.alu[DMEM_AW+1:2];

    always_ff @(posedge aclk) begin
        if (ex_mem.valid && ex_mem.mem_wr)
            dmem[widx] <= ex_mem.st_data;
    end

    // load data is not ready yet, so no bypass from here
    assign mem_fwd = '{reg_wr: ex_mem.valid && ex_mem.reg_wr && !ex_mem.mem_rd,
                       dst: ex_mem.dst, value: ex_mem.alu};

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb.valid  <= ex_mem.valid;
            mem_wb.pc     <= ex_mem.pc;
            mem_wb.result <= ex_mem.mem_rd ? dmem[widx] : ex_mem.alu;
            mem_wb.dst    <= ex_mem.dst;
            mem_wb.reg_wr <= ex_mem.reg_wr;
        end
    end

    assign wb_fwd = '{reg_wr: mem_wb.valid && mem_wb.reg_wr, dst: mem_wb.dst,
                      value: mem_wb.result};

    assign debug_wb_pc       = mem_wb.pc;
    assign debug_wb_rf_wdata = mem_wb.result;
    assign debug_wb_rf_wen   = (wb_fwd.reg_wr && mem_wb.dst != '0) ? 4'hf : 4'h0;
    assign debug_wb_rf_wnum  = mem_wb.dst;

    // one RAM access per instruction
    a_rd_wr_excl: assert property (@(posedge aclk) disable iff (!arst_n)
        ex_mem.valid && ex_mem.mem_rd |-> !ex_mem.mem_wr);

endmodule

// File: design/execute.sv
////////////////////////////////////////
// branches resolve here, taken costs 2
// bypass order is memory, writeback, decode
////////////////////////////////////////
`timescale 1ns/1ps

module execute (
    input  logic             aclk,
    input  logic             arst_n,
    input  cpu_pkg::id_ex_t  id_ex,
    input  cpu_pkg::fwd_t    mem_fwd,
    input  cpu_pkg::fwd_t    wb_fwd,
    output logic             redirect,
    output cpu_pkg::word_t   redirect_pc,
    output cpu_pkg::ex_mem_t ex_mem
);
    import cpu_pkg::*;

    word_t rs_fwd;
    word_t rt_fwd;
    word_t op_b;
    word_t alu_res;
    logic  br_eq;

    function automatic word_t pick(reg_idx_t src, word_t dec_val, fwd_t m, fwd_t w);
        if (src == '0)
            return dec_val;
        if (m.reg_wr && m.dst == src)
            return m.value;
        if (w.reg_wr && w.dst == src)
            return w.value;
        return dec_val;
    endfunction

    always_comb begin
        rs_fwd = pick(id_ex.rs, id_ex.rs_val, mem_fwd, wb_fwd);
        rt_fwd = pick(id_ex.rt, id_ex.rt_val, mem_fwd, wb_fwd);
        op_b   = id_ex.use_imm ? id_ex.imm : rt_fwd;
        case (id_ex.alu_op)
            ALU_SUB: alu_res = rs_fwd - op_b;
            ALU_AND: alu_res = rs_fwd & op_b;
            ALU_OR:  alu_res = rs_fwd | op_b;
            ALU_XOR: alu_res = rs_fwd ^ op_b;
            ALU_SLT: alu_res = {31'd0, $signed(rs_fwd) < $signed(op_b)};
            ALU_LUI: alu_res = {op_b[15:0], 16'h0000};
            default: alu_res = rs_fwd + op_b;  // add, address calc
        endcase
    end

    assign br_eq       = (rs_fwd == rt_fwd);
    assign redirect    = id_ex.valid && ((id_ex.is_beq && br_eq) || (id_ex.is_bne && !br_eq));
    assign redirect_pc = id_ex.pc + 32'd4 + {id_ex.imm[29:0], 2'b00};

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid   <= id_ex.valid && !redirect;  // taken branch retires silently
            ex_mem.pc      <= id_ex.pc;
            ex_mem.alu     <= alu_res;
            ex_mem.st_data <= rt_fwd;
            ex_mem.dst     <= id_ex.dst;
            ex_mem.reg_wr  <= id_ex.reg_wr;
            ex_mem.mem_rd  <= id_ex.mem_rd;
            ex_mem.mem_wr  <= id_ex.mem_wr;
        end
    end

endmodule

// File: design/inst_decode.sv
////////////////////////////////////////
// unknown encodings decode to a bubble
// with no register or memory write
// stalls one cycle on load-use
////////////////////////////////////////
`timescale 1ns/1ps

module inst_decode (
    input  logic              aclk,
    input  logic              arst_n,
    input  cpu_pkg::if_id_t   if_id,
    input  logic              id_flush,
    output cpu_pkg::id_ex_t   id_ex,
    output logic              load_use,
    output cpu_pkg::reg_idx_t rs,
    output cpu_pkg::reg_idx_t rt,
    input  cpu_pkg::word_t    rs_val,
    input  cpu_pkg::word_t    rt_val
);
    import cpu_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t   rd;
    logic       use_rs;
    logic       use_rt;
    id_ex_t     dec;

    assign opcode = if_id.instr[31:26];
    assign rs     = if_id.instr[25:21];
    assign rt     = if_id.instr[20:16];
    assign rd     = if_id.instr[15:11];
    assign funct  = if_id.instr[5:0];

    always_comb begin
        dec        = '0;
        use_rs     = 1'b0;
        use_rt     = 1'b0;
        dec.valid  = 1'b1;
        dec.pc     = if_id.pc;
        dec.rs_val = rs_val;
        dec.rt_val = rt_val;
        dec.rs     = rs;
        dec.rt     = rt;
        dec.imm    = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
        dec.dst    = rt;  // I-type target
        case (opcode)
            OP_SPECIAL: begin
                dec.dst    = rd;
                dec.reg_wr = 1'b1;
                use_rs     = 1'b1;
                use_rt     = 1'b1;
                case (funct)
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    default: begin
                        dec.reg_wr = 1'b0;  // sll 0 etc, runs as nop
                        use_rs     = 1'b0;
                        use_rt     = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_LW: begin
                dec.use_imm = 1'b1;
                dec.reg_wr  = 1'b1;
                dec.mem_rd  = (opcode == OP_LW);
                use_rs      = 1'b1;
            end
            OP_LUI: begin
                dec.alu_op  = ALU_LUI;
                dec.use_imm = 1'b1;
                dec.reg_wr  = 1'b1;
            end
            OP_SW: begin
                dec.use_imm = 1'b1;
                dec.mem_wr  = 1'b1;
                use_rs      = 1'b1;
                use_rt      = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                dec.is_beq = (opcode == OP_BEQ);
                dec.is_bne = (opcode == OP_BNE);
                use_rs     = 1'b1;
                use_rt     = 1'b1;
            end
            default: ;
        endcase
        if (!if_id.valid) begin
            dec    = '0;
            use_rs = 1'b0;
            use_rt = 1'b0;
        end
    end

    // load in execute feeding a source read here
    assign load_use = id_ex.valid && id_ex.mem_rd && id_ex.dst != '0 &&
                      ((use_rs && id_ex.dst == rs) || (use_rt && id_ex.dst == rt));

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n)
            id_ex <= '0;
        else if (id_flush)
            id_ex <= '0;  // bubble
        else
            id_ex <= dec;
    end

    // stalled instruction stays put unless a taken branch squashes it
    a_stall_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        load_use |=> !if_id.valid || if_id == $past(if_id));

endmodule

// File: design/reg_file.sv
////////////////////////////////////////
// 32 x 32, r0 always reads zero
// write in the same cycle bypasses reads
////////////////////////////////////////
`timescale 1ns/1ps

module reg_file (
    input  logic              aclk,
    input  logic              arst_n,
    input  cpu_pkg::reg_idx_t rs,
    input  cpu_pkg::reg_idx_t rt,
    output cpu_pkg::word_t    rs_val,
    output cpu_pkg::word_t    rt_val,
    input  cpu_pkg::fwd_t     wb
);
    import cpu_pkg::*;

    word_t regs [32];  // entry 0 never written

    function automatic word_t read_port(reg_idx_t idx);
        if (idx == '0)
            return '0;
        if (wb.reg_wr && wb.dst == idx)
            return wb.value;  // writeback in flight
        return regs[idx];
    endfunction

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wb.reg_wr && wb.dst != '0) begin
            regs[wb.dst] <= wb.value;
        end
    end

    always_comb begin
        rs_val = read_port(rs);
        rt_val = read_port(rt);
    end

endmodule

// File: design/inst_fetch.sv
////////////////////////////////////////
// pc starts at zero after reset
// imem is combinational, read same cycle
// redirect target must be word aligned
////////////////////////////////////////
`timescale 1ns/1ps

module inst_fetch (
    input  logic            aclk,
    input  logic            arst_n,
    input  logic            pc_wr,
    input  logic            if_wr,
    input  logic            if_flush,
    input  logic            redirect,
    input  cpu_pkg::word_t  redirect_pc,
    output cpu_pkg::word_t  imem_addr,
    input  cpu_pkg::word_t  imem_data,
    output cpu_pkg::if_id_t if_id
);
    import cpu_pkg::*;

    word_t pc;
    word_t pc_next;

    assign pc_next   = redirect ? redirect_pc : pc + 32'd4;
    assign imem_addr = pc;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n)
            pc <= '0;
        else if (pc_wr)
            pc <= pc_next;
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n)
            if_id <= '0;
        else if (if_flush)
            if_id <= '0;  // wrong-path fetch
        else if (if_wr)
            if_id <= '{valid: 1'b1, pc: pc, instr: imem_data};
    end

    a_pc_aligned: assert property (@(posedge aclk) disable iff (!arst_n) pc[1:0] == 2'b00);

endmodule

// File: design/cpu_pkg.sv
////////////////////////////////////////
// types shared by the five-stage core
// MIPS-like integer subset, no delay slot
// data RAM is 64 words, word index only
////////////////////////////////////////
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);  // address bits above the byte offset

    // major opcode, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_LUI     = 6'h0F;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2B;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;

    // funct field of SPECIAL, instr[5:0]
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2A;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    rs_val;
        word_t    rt_val;
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    imm;      // sign extended
        alu_op_e  alu_op;
        logic     use_imm;
        reg_idx_t dst;
        logic     reg_wr;
        logic     mem_rd;
        logic     mem_wr;
        logic     is_beq;
        logic     is_bne;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    alu;
        word_t    st_data;
        reg_idx_t dst;
        logic     reg_wr;
        logic     mem_rd;
        logic     mem_wr;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    result;
        reg_idx_t dst;
        logic     reg_wr;
    } mem_wb_t;

    // bypass source, also the register file write port
    typedef struct packed {
        logic     reg_wr;
        reg_idx_t dst;
        word_t    value;
    } fwd_t;

endpackage
